// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mv_accel_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
hdl/mac_pkg.sv
hdl/apb_cfg_regs.sv
hdl/tile_sequencer.sv
hdl/pe_array.sv
hdl/acc_counter.sv
hdl/psum_accumulator.sv
hdl/mv_accel_top.sv
verif/mv_accel_tb.sv

// File: hdl/acc_counter.sv
`timescale 1ns/1ns

module acc_counter import mac_pkg::*; #(
    parameter int WEIGHT_ROW_NUM = 8,
    parameter int WEIGHT_COL_NUM = 6
) (
    input  logic clk,
    input  logic rst_n,
    input  logic psum_en,
    output logic ofmap_valid,
    output logic buf_clear
);

    localparam int tile_num = WEIGHT_ROW_NUM / pe_size;
    localparam int tile_w = (tile_num > 1) ? $clog2(tile_num) : 1;
    localparam int cnt_w = $clog2(WEIGHT_COL_NUM + 1);

    logic [cnt_w-1:0]  psum_cnt;
    logic [tile_w-1:0] acc_cnt;
    logic              psum_wrap;
    logic              last_tile;

    // Counter parks one cycle at COL before wrapping
    assign psum_wrap = (psum_cnt == cnt_w'(WEIGHT_COL_NUM));
    assign last_tile = (acc_cnt == tile_w'(tile_num - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_cnt <= '0;
        end else if (psum_wrap) begin
            psum_cnt <= '0;
        end else if (psum_en) begin
            psum_cnt <= psum_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_cnt <= '0;
        end else if (psum_wrap) begin
            acc_cnt <= last_tile ? '0 : acc_cnt + 1'b1;
        end
    end

    // Partial sums of the last tile complete the column totals
    assign ofmap_valid = last_tile & psum_en;
    assign buf_clear = last_tile & psum_wrap;

    a_no_psum_at_wrap : assert property (
        @(posedge clk) disable iff (!rst_n)
        psum_wrap |-> !psum_en
    );

endmodule

// File: hdl/apb_cfg_regs.sv
`timescale 1ns/1ns

module apb_cfg_regs import mac_pkg::*; #(
    parameter int WEIGHT_ROW_NUM = 8,
    parameter int WEIGHT_COL_NUM = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  start,
    input  logic [((WEIGHT_ROW_NUM / pe_size) > 1 ?
                   $clog2(WEIGHT_ROW_NUM / pe_size) : 1)-1:0] tile,
    input  logic [$clog2(WEIGHT_COL_NUM + 1)-1:0] col,
    input  logic                  busy,
    input  logic                  buf_clear,
    output apb_word_u             act_word,
    output apb_word_u             wgt_word
);

    localparam int tile_num = WEIGHT_ROW_NUM / pe_size;
    localparam int tile_w = (tile_num > 1) ? $clog2(tile_num) : 1;
    localparam int wgt_num = tile_num * WEIGHT_COL_NUM;
    localparam int wgt_idx_w = (wgt_num > 1) ? $clog2(wgt_num) : 1;

    apb_word_u act_mem [tile_num];
    apb_word_u wgt_mem [wgt_num];

    logic                  access;
    logic                  wr_en;
    logic                  rd_en;
    logic [apb_addr_w-1:0] act_off;
    logic [apb_addr_w-1:0] wgt_off;
    logic                  act_hit;
    logic                  wgt_hit;
    logic [tile_w-1:0]     act_idx;
    logic [wgt_idx_w-1:0]  wgt_idx;
    logic [wgt_idx_w-1:0]  iss_idx;
    logic                  done;
    logic [31:0]           status_word;

    // Zero wait state access phase
    assign access = psel & penable;
    assign wr_en = access & pwrite;
    assign rd_en = access & ~pwrite;

    // Region decode, word index from byte offset
    assign act_off = paddr - act_base;
    assign wgt_off = paddr - wgt_base;
    assign act_hit = (paddr >= act_base) && (act_off[apb_addr_w-1:2] < tile_num);
    assign wgt_hit = (paddr >= wgt_base) && (wgt_off[apb_addr_w-1:2] < wgt_num);
    assign act_idx = act_off[2 +: tile_w];
    assign wgt_idx = wgt_off[2 +: wgt_idx_w];

    assign start = wr_en && (paddr == ctrl_addr) && pwdata[ctrl_start_bit];

    always_ff @(posedge clk) begin
        if (wr_en && act_hit) begin
            act_mem[act_idx].raw <= pwdata;
        end
        if (wr_en && wgt_hit) begin
            wgt_mem[wgt_idx].raw <= pwdata;
        end
    end

    // Sticky done, a new run clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (start && !busy) begin
            done <= 1'b0;
        end else if (buf_clear) begin
            done <= 1'b1;
        end
    end

    always_comb begin
        status_word = '0;
        status_word[status_busy_bit] = busy;
        status_word[status_done_bit] = done;
    end

    always_comb begin
        prdata = '0;
        if (rd_en) begin
            if (paddr == status_addr) begin
                prdata = status_word;
            end else if (wgt_hit) begin
                prdata = wgt_mem[wgt_idx].raw;
            end
        end
    end

    // Operand fetch for the sequencer's current tile and column
    assign iss_idx = wgt_idx_w'(tile * WEIGHT_COL_NUM + col);
    assign act_word = act_mem[tile];
    assign wgt_word = (col < WEIGHT_COL_NUM) ? wgt_mem[iss_idx] : '0;

    a_paddr_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> (paddr[1:0] == 2'b00)
    );

endmodule

// File: hdl/mac_pkg.sv
package mac_pkg;

    // Lanes per PE array, also rows per tile
    localparam int pe_size = 4;

    // APB address width
    localparam int apb_addr_w = 12;

    // Signed weight or activation
    typedef logic signed [7:0] data_t;

    // Signed partial or final sum
    typedef logic signed [31:0] psum_t;

    // One APB word, seen either raw or as four int8 lanes
    // Lane 0 sits in the low byte
    typedef union packed {
        logic [31:0] raw;
        data_t [pe_size-1:0] lanes;
    } apb_word_u;

    // Register map
    localparam logic [apb_addr_w-1:0] ctrl_addr = 12'h000;
    localparam logic [apb_addr_w-1:0] status_addr = 12'h004;
    localparam logic [apb_addr_w-1:0] act_base = 12'h100;
    localparam logic [apb_addr_w-1:0] wgt_base = 12'h400;

    // Bit positions inside ctrl and status
    localparam int ctrl_start_bit = 0;
    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;

endpackage

// File: hdl/mv_accel_top.sv
`timescale 1ns/1ns

module mv_accel_top import mac_pkg::*; #(
    parameter int WEIGHT_ROW_NUM = 8,
    parameter int WEIGHT_COL_NUM = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output psum_t                 ofmap_data,
    output logic                  ofmap_valid,
    output logic [$clog2(WEIGHT_COL_NUM + 1)-1:0] ofmap_col
);

    localparam int tile_num = WEIGHT_ROW_NUM / pe_size;
    localparam int tile_w = (tile_num > 1) ? $clog2(tile_num) : 1;
    localparam int col_w = $clog2(WEIGHT_COL_NUM + 1);

    logic              start;
    logic              busy;
    logic              issue;
    logic [tile_w-1:0] tile;
    logic [col_w-1:0]  col;
    apb_word_u         act_word;
    apb_word_u         wgt_word;
    psum_t             psum;
    logic              psum_en;
    logic [col_w-1:0]  psum_col;
    logic              last_valid;
    logic              buf_clear;

    apb_cfg_regs #(
        .WEIGHT_ROW_NUM(WEIGHT_ROW_NUM),
        .WEIGHT_COL_NUM(WEIGHT_COL_NUM)
    ) apb_cfg_regs_i (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .start(start), .tile(tile), .col(col), .busy(busy),
        .buf_clear(buf_clear), .act_word(act_word), .wgt_word(wgt_word)
    );

    tile_sequencer #(
        .WEIGHT_ROW_NUM(WEIGHT_ROW_NUM),
        .WEIGHT_COL_NUM(WEIGHT_COL_NUM)
    ) tile_sequencer_i (
        .clk(clk), .rst_n(rst_n), .start(start), .issue(issue),
        .tile(tile), .col(col), .busy(busy)
    );

    pe_array #(
        .WEIGHT_COL_NUM(WEIGHT_COL_NUM)
    ) pe_array_i (
        .clk(clk), .rst_n(rst_n), .issue(issue), .col(col),
        .act_word(act_word), .wgt_word(wgt_word), .psum(psum),
        .psum_en(psum_en), .psum_col(psum_col)
    );

    acc_counter #(
        .WEIGHT_ROW_NUM(WEIGHT_ROW_NUM),
        .WEIGHT_COL_NUM(WEIGHT_COL_NUM)
    ) acc_counter_i (
        .clk(clk), .rst_n(rst_n), .psum_en(psum_en),
        .ofmap_valid(last_valid), .buf_clear(buf_clear)
    );

    psum_accumulator #(
        .WEIGHT_ROW_NUM(WEIGHT_ROW_NUM),
        .WEIGHT_COL_NUM(WEIGHT_COL_NUM)
    ) psum_accumulator_i (
        .clk(clk), .rst_n(rst_n), .psum(psum), .psum_en(psum_en),
        .psum_col(psum_col), .ofmap_valid(last_valid), .buf_clear(buf_clear),
        .ofmap_data(ofmap_data), .ofmap_valid_q(ofmap_valid), .ofmap_col(ofmap_col)
    );

endmodule

// File: hdl/pe_array.sv
`timescale 1ns/1ns

module pe_array import mac_pkg::*; #(
    parameter int WEIGHT_COL_NUM = 6
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue,
    input  logic [$clog2(WEIGHT_COL_NUM + 1)-1:0] col,
    input  apb_word_u act_word,
    input  apb_word_u wgt_word,
    output psum_t     psum,
    output logic      psum_en,
    output logic [$clog2(WEIGHT_COL_NUM + 1)-1:0] psum_col
);

    logic signed [15:0] prod [pe_size];
    logic signed [16:0] pair_sum [2];
    psum_t              tree_sum;

    // One signed multiplier per lane
    always_comb begin
        for (int i = 0; i < pe_size; i++) begin
            prod[i] = act_word.lanes[i] * wgt_word.lanes[i];
        end
    end

    // Two level adder tree
    assign pair_sum[0] = prod[0] + prod[1];
    assign pair_sum[1] = prod[2] + prod[3];
    assign tree_sum = psum_t'(pair_sum[0]) + psum_t'(pair_sum[1]);

    always_ff @(posedge clk) begin
        if (issue) begin
            psum <= tree_sum;
            psum_col <= col;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_en <= 1'b0;
        end else begin
            psum_en <= issue;
        end
    end

endmodule

// File: hdl/psum_accumulator.sv
`timescale 1ns/1ns

module psum_accumulator import mac_pkg::*; #(
    parameter int WEIGHT_ROW_NUM = 8,
    parameter int WEIGHT_COL_NUM = 6
) (
    input  logic  clk,
    input  logic  rst_n,
    input  psum_t psum,
    input  logic  psum_en,
    input  logic [$clog2(WEIGHT_COL_NUM + 1)-1:0] psum_col,
    input  logic  ofmap_valid,
    input  logic  buf_clear,
    output psum_t ofmap_data,
    output logic  ofmap_valid_q,
    output logic [$clog2(WEIGHT_COL_NUM + 1)-1:0] ofmap_col
);

    psum_t acc_buf [WEIGHT_COL_NUM];
    psum_t acc_sum;

    // Running total including the incoming partial sum
    assign acc_sum = acc_buf[psum_col] + psum;

    // Buffer comes out of reset empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < WEIGHT_COL_NUM; i++) begin
                acc_buf[i] <= '0;
            end
        end else if (buf_clear) begin
            for (int i = 0; i < WEIGHT_COL_NUM; i++) begin
                acc_buf[i] <= '0;
            end
        end else if (psum_en) begin
            acc_buf[psum_col] <= acc_sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofmap_valid_q <= 1'b0;
        end else begin
            ofmap_valid_q <= ofmap_valid;
        end
    end

    // Final total leaves with its column tag
    always_ff @(posedge clk) begin
        if (ofmap_valid) begin
            ofmap_data <= acc_sum;
            ofmap_col <= psum_col;
        end
    end

    a_col_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        psum_en |-> (psum_col < WEIGHT_COL_NUM)
    );

endmodule

// File: hdl/tile_sequencer.sv
`timescale 1ns/1ns

module tile_sequencer import mac_pkg::*; #(
    parameter int WEIGHT_ROW_NUM = 8,
    parameter int WEIGHT_COL_NUM = 6
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic issue,
    output logic [((WEIGHT_ROW_NUM / pe_size) > 1 ?
                   $clog2(WEIGHT_ROW_NUM / pe_size) : 1)-1:0] tile,
    output logic [$clog2(WEIGHT_COL_NUM + 1)-1:0] col,
    output logic busy
);

    localparam int tile_num = WEIGHT_ROW_NUM / pe_size;
    localparam int tile_w = (tile_num > 1) ? $clog2(tile_num) : 1;
    localparam int col_w = $clog2(WEIGHT_COL_NUM + 1);

    logic last_col;
    logic last_tile;

    // col == COL is the bubble slot closing each tile
    assign last_col = (col == col_w'(WEIGHT_COL_NUM));
    assign last_tile = (tile == tile_w'(tile_num - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            tile <= '0;
            col <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                tile <= '0;
                col <= '0;
            end
        end else if (last_col) begin
            col <= '0;
            if (last_tile) begin
                busy <= 1'b0;
            end else begin
                tile <= tile + 1'b1;
            end
        end else begin
            col <= col + 1'b1;
        end
    end

    assign issue = busy && !last_col;

    // Start from the register block is a single cycle pulse
    a_start_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        start |=> !start
    );

endmodule

// File: verif/mv_accel_tb.sv
`timescale 1ns/1ns

module mv_accel_tb import mac_pkg::*; ();

    localparam int row_num = 8;
    localparam int col_num = 6;
    localparam int tile_num = row_num / pe_size;
    localparam int col_w = $clog2(col_num + 1);
    localparam int pat_random = 0;
    localparam int pat_max = 1;
    localparam int pat_min = 2;
    localparam int pat_zero_act = 3;
    localparam int pat_alt = 4;
    localparam int num_cases = 6;
    // Three clocks per APB transfer
    localparam int apb_cycles = 3 * (2 * tile_num * col_num + tile_num + 3);
    localparam int run_cycles = tile_num * (col_num + 1);
    localparam int timeout_cycles = num_cases * (run_cycles + apb_cycles) * 2;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    psum_t                 ofmap_data;
    logic                  ofmap_valid;
    logic [col_w-1:0]      ofmap_col;

    // Stimulus table, pattern kind and weight readback flag
    int    case_kind [num_cases] = '{pat_random, pat_max, pat_min, pat_zero_act, pat_alt,
                                     pat_random};
    bit    case_readback [num_cases] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
    int    seed = 27;
    int    cycle_cnt = 0;
    int    access_cyc;
    int    act_ref [row_num];
    int    wgt_ref [row_num][col_num];
    psum_t exp_ofmap [col_num];
    psum_t got_data [$];
    int    got_col [$];
    int    got_cyc [$];

    mv_accel_top #(.WEIGHT_ROW_NUM(row_num), .WEIGHT_COL_NUM(col_num)) mv_accel_top_i (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .ofmap_data(ofmap_data),
        .ofmap_valid(ofmap_valid), .ofmap_col(ofmap_col)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("The run timed out after %0d cycles without finishing", cycle_cnt);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // Ofmap monitor, stamped with the cycle count
    always @(negedge clk) begin
        if (ofmap_valid) begin
            got_data.push_back(ofmap_data);
            got_col.push_back(int'(ofmap_col));
            got_cyc.push_back(cycle_cnt);
        end
    end

    task automatic stop_with_error(string msg);
        $display("ERROR @ %0t ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_word(apb_word_u got, apb_word_u exp, string what);
        for (int i = 0; i < pe_size; i++) begin
            if (got.lanes[i] !== exp.lanes[i]) begin
                stop_with_error($sformatf("%s lane %0d read %0d, expected %0d",
                                          what, i, got.lanes[i], exp.lanes[i]));
            end
        end
    endtask

    task automatic check_ofmap(psum_t got, psum_t exp, int got_c, int exp_c);
        if (got_c != exp_c || got !== exp) begin
            stop_with_error($sformatf("ofmap col %0d = %0d, expected col %0d = %0d",
                                      got_c, got, exp_c, exp));
        end
    endtask

    task automatic check_status(logic [31:0] got, logic busy_exp, logic done_exp);
        if (got[status_busy_bit] !== busy_exp || got[status_done_bit] !== done_exp) begin
            stop_with_error($sformatf("status busy=%b done=%b, expected busy=%b done=%b",
                                      got[status_busy_bit], got[status_done_bit],
                                      busy_exp, done_exp));
        end
    endtask

    task automatic apb_write(logic [apb_addr_w-1:0] addr, logic [31:0] data);
        @(posedge clk);
        psel <= 1'b1;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        access_cyc = cycle_cnt;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(logic [apb_addr_w-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel <= 1'b1;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic int rand_byte();
        logic [7:0] b;
        b = 8'($random(seed));
        return int'($signed(b));
    endfunction

    task automatic fill_pattern(int kind);
        for (int r = 0; r < row_num; r++) begin
            case (kind)
                pat_max:      act_ref[r] = 127;
                pat_min:      act_ref[r] = -128;
                pat_zero_act: act_ref[r] = 0;
                pat_alt:      act_ref[r] = (r % 2 == 0) ? 127 : -128;
                default:      act_ref[r] = rand_byte();
            endcase
            for (int c = 0; c < col_num; c++) begin
                case (kind)
                    pat_max: wgt_ref[r][c] = 127;
                    pat_min: wgt_ref[r][c] = -128;
                    pat_alt: wgt_ref[r][c] = ((r + c) % 2 == 1) ? -128 : 127;
                    default: wgt_ref[r][c] = rand_byte();
                endcase
            end
        end
        // Dot product of activations with each weight column
        for (int c = 0; c < col_num; c++) begin
            exp_ofmap[c] = '0;
            for (int r = 0; r < row_num; r++) begin
                exp_ofmap[c] = exp_ofmap[c] + psum_t'(act_ref[r] * wgt_ref[r][c]);
            end
        end
    endtask

    function automatic apb_word_u wgt_word_of(int t, int c);
        apb_word_u w;
        for (int i = 0; i < pe_size; i++) begin
            w.lanes[i] = data_t'(wgt_ref[t * pe_size + i][c]);
        end
        return w;
    endfunction

    task automatic load_operands(bit readback);
        apb_word_u w;
        logic [31:0] rd;
        for (int t = 0; t < tile_num; t++) begin
            for (int i = 0; i < pe_size; i++) begin
                w.lanes[i] = data_t'(act_ref[t * pe_size + i]);
            end
            apb_write(act_base + apb_addr_w'(4 * t), w.raw);
            for (int c = 0; c < col_num; c++) begin
                apb_write(wgt_base + apb_addr_w'(4 * (t * col_num + c)), wgt_word_of(t, c));
            end
        end
        for (int t = 0; t < tile_num && readback; t++) begin
            for (int c = 0; c < col_num; c++) begin
                apb_read(wgt_base + apb_addr_w'(4 * (t * col_num + c)), rd);
                check_word(rd, wgt_word_of(t, c), $sformatf("weight t%0d c%0d", t, c));
            end
        end
    endtask

    task automatic run_and_check();
        logic [31:0] status;
        int first_cyc;
        got_data.delete();
        got_col.delete();
        got_cyc.delete();
        apb_write(ctrl_addr, 32'h1);
        // Last tile's ofmaps lag its first issue by two cycles
        first_cyc = access_cyc + 1 + (tile_num - 1) * (col_num + 1) + 2;
        apb_read(status_addr, status);
        check_status(status, 1'b1, 1'b0);
        while (got_col.size() < col_num) begin
            @(negedge clk);
        end
        for (int i = 0; i < col_num; i++) begin
            check_ofmap(got_data[i], exp_ofmap[i], got_col[i], i);
            if (got_cyc[i] != first_cyc + i) begin
                stop_with_error($sformatf("ofmap %0d at cycle %0d, expected cycle %0d",
                                          i, got_cyc[i], first_cyc + i));
            end
        end
        apb_read(status_addr, status);
        check_status(status, 1'b0, 1'b1);
        if (got_col.size() != col_num) begin
            stop_with_error($sformatf("%0d ofmaps seen, expected %0d", got_col.size(), col_num));
        end
    endtask

    initial begin
        logic [31:0] status;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        apb_read(status_addr, status);
        check_status(status, 1'b0, 1'b0);
        for (int n = 0; n < num_cases; n++) begin
            fill_pattern(case_kind[n]);
            load_operands(case_readback[n]);
            run_and_check();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule
